// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := cdc_fifo_tb
FILELIST  := project.f
BUILD_DIR := obj_dir
SIM_ARGS  := +verilator+error+limit+1000
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: project.f
src/cdc_fifo_pkg.sv
src/flop_ram_1r1w.sv
src/gray_ptr_sync.sv
src/cdc_fifo_push_ctrl.sv
src/cdc_fifo_pop_ctrl.sv
src/cdc_fifo_flops_push_credit.sv
sim/cdc_fifo_properties.sv
sim/cdc_fifo_tb.sv

// File: sim/cdc_fifo_properties.sv
// Concurrent checks on the FIFO top-level ports.
// Bound into every instance of the FIFO top level.

`timescale 1ns/10ps

module cdc_fifo_properties (
  input logic                 push_clk,
  input logic                 pop_clk,
  input logic                 rst_n,
  input logic                 push_credit_stall,
  input logic                 push_credit,
  input logic                 push_valid,
  input logic                 push_full,
  input logic                 pop_valid,
  input cdc_fifo_pkg::data_t  pop_data,
  input cdc_fifo_pkg::count_t pop_items
);

  // Number of failed assertions, read by the testbench at the end
  int fail_count = 0;

  // A stall freezes the credit link in the same cycle
  credit_held_in_stall: assert property (
    @(posedge push_clk) disable iff (!rst_n) push_credit_stall |-> !push_credit
  ) else begin
    fail_count++;
    $error("push_credit high while push_credit_stall is high");
  end

  // The sender spends credits only, so a push never meets a full FIFO
  no_push_when_full: assert property (
    @(posedge push_clk) disable iff (!rst_n) push_valid |-> !push_full
  ) else begin
    fail_count++;
    $error("push_valid high while push_full is high");
  end

  pop_data_zero_idle: assert property (
    @(posedge pop_clk) disable iff (!rst_n) !pop_valid |-> (pop_data == '0)
  ) else begin
    fail_count++;
    $error("pop_data not zero while pop_valid is low");
  end

  pop_items_bounded: assert property (
    @(posedge pop_clk) disable iff (!rst_n) pop_items <= cdc_fifo_pkg::depth
  ) else begin
    fail_count++;
    $error("pop_items above the FIFO depth");
  end

endmodule

bind cdc_fifo_flops_push_credit cdc_fifo_properties props_i (.*);

// File: sim/cdc_fifo_tb.sv
// Testbench for the dual-clock FIFO with push credit.
// A credit sender model pushes random words and a queue model checks every pop.

`timescale 1ns/10ps

module cdc_fifo_tb;

  // Number of words pushed in the run also sizes the watchdog
  localparam int num_pushes = 200;

  logic push_clk, pop_clk, rst_n;
  logic push_sender_in_reset, push_credit_stall, push_valid, pop_ready;
  logic push_receiver_in_reset, push_credit, push_full, pop_valid, pop_empty;
  cdc_fifo_pkg::data_t  push_data, pop_data;
  cdc_fifo_pkg::count_t push_slots, credit_count, pop_items;

  // Words in flight with the oldest at the front
  cdc_fifo_pkg::data_t model_q [$];

  // Credits the sender holds and the bookkeeping counters of the run
  int credits, push_count, pop_count, error_count, waited;

  // 0 holds pop_ready low, 1 randomizes it, 2 holds it high
  int pop_mode;

  cdc_fifo_flops_push_credit dut_i (.*);

  initial begin
    push_clk = 1'b0;
    forever #5 push_clk = ~push_clk;
  end

  // Same period as push_clk but shifted so the two domains never share an edge
  initial begin
    pop_clk = 1'b0;
    #3.7;
    forever #5 pop_clk = ~pop_clk;
  end

  // Expected pop_data is zero without valid and otherwise the oldest queued word
  function automatic cdc_fifo_pkg::data_t expected_pop_data(input logic valid);
    if (!valid || model_q.size() == 0) begin
      return '0;
    end
    return model_q[0];
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      error_count++;
    end
  endtask

  task automatic finish_run();
    $display("Pushes %0d, pops %0d, test errors %0d, assertion errors %0d",
             push_count, pop_count, error_count, dut_i.props_i.fail_count);
    if (error_count == 0 && dut_i.props_i.fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  // A credit pulse gives the sender one credit and each push spends one
  always @(posedge push_clk) begin
    if (!rst_n) begin
      credits = 0;
    end else begin
      if (push_credit && (push_credit_stall || push_sender_in_reset)) begin
        $display("Credit pulse arrived while the link was stalled or in reset at %0t", $time);
        error_count++;
      end
      credits = credits + int'(push_credit) - int'(push_valid);
    end
  end

  // Every visible word must match the queue front; a handshake retires it
  always @(posedge pop_clk) begin
    if (rst_n) begin
      check_eq("pop_data", pop_data, expected_pop_data(pop_valid));
      if (pop_valid && model_q.size() == 0) begin
        $display("FIFO shows valid data while no word is queued at %0t", $time);
        error_count++;
      end else if (pop_valid && pop_ready) begin
        void'(model_q.pop_front());
        pop_count++;
      end
    end
  end

  initial begin
    pop_ready = 1'b0;
    forever begin
      @(posedge pop_clk);
      #1;
      case (pop_mode)
        0:       pop_ready = 1'b0;
        1:       pop_ready = (($urandom % 100) < 60);
        default: pop_ready = 1'b1;
      endcase
    end
  end

  // Pushes n words and spends one held credit on each
  // Random mode adds idle gaps and credit stalls
  task automatic send_words(input int n, input bit random_mode);
    int sent;
    sent = 0;
    while (sent < n) begin
      @(posedge push_clk);
      #1;
      push_valid = 1'b0;
      if (random_mode) begin
        push_credit_stall = (($urandom % 4) == 0);
      end
      if (credits > 0 && (!random_mode || ($urandom % 100) < 70)) begin
        push_data  = cdc_fifo_pkg::data_t'($urandom);
        push_valid = 1'b1;
        model_q.push_back(push_data);
        sent++;
        push_count++;
      end
    end
    @(posedge push_clk);
    #1;
    push_valid        = 1'b0;
    push_credit_stall = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h5228_a42a));
    rst_n = 1'b0;
    push_sender_in_reset = 1'b0;
    push_credit_stall = 1'b0;
    push_valid = 1'b0;
    push_data = '0;
    pop_mode = 0;
    credits = 0;
    push_count = 0;
    pop_count = 0;
    error_count = 0;
    // Outputs hold their reset values from the first edge on
    repeat (2) @(posedge push_clk);
    #1;
    check_eq("push_receiver_in_reset", push_receiver_in_reset, 1);
    check_eq("push_credit", push_credit, 0);
    check_eq("push_full", push_full, 0);
    check_eq("credit_count", credit_count, cdc_fifo_pkg::depth);
    check_eq("pop_valid", pop_valid, 0);
    check_eq("pop_empty", pop_empty, 1);
    check_eq("pop_data", pop_data, 0);
    repeat (3) @(posedge push_clk);
    #1;
    rst_n = 1'b1;
    push_sender_in_reset = 1'b1;
    // Sender in reset and then a stall must both hold the credits back
    repeat (4) @(posedge push_clk);
    #1;
    push_sender_in_reset = 1'b0;
    push_credit_stall = 1'b1;
    repeat (4) @(posedge push_clk);
    #1;
    push_credit_stall = 1'b0;
    check_eq("sender_credits", credits, 0);
    waited = 0;
    while (credits < cdc_fifo_pkg::depth && waited < 100) begin
      @(posedge push_clk);
      #1;
      waited++;
    end
    // Extra cycles show that no credit beyond depth follows
    repeat (20) @(posedge push_clk);
    #1;
    check_eq("sender_credits", credits, cdc_fifo_pkg::depth);
    check_eq("credit_count", credit_count, 0);
    // Fill the FIFO with pop_ready low
    send_words(cdc_fifo_pkg::depth, 1'b0);
    check_eq("push_full", push_full, 1);
    check_eq("push_slots", push_slots, 0);
    check_eq("sender_credits", credits, 0);
    repeat (cdc_fifo_pkg::num_sync_stages + 2) @(posedge pop_clk);
    #1;
    check_eq("pop_items", pop_items, cdc_fifo_pkg::depth);
    // Random traffic is followed by a drain with pop_ready high
    pop_mode = 1;
    send_words(num_pushes - cdc_fifo_pkg::depth, 1'b1);
    pop_mode = 2;
    waited = 0;
    while (model_q.size() != 0 && waited < 500) begin
      @(posedge push_clk);
      #1;
      waited++;
    end
    if (model_q.size() != 0) begin
      $display("FIFO did not drain, %0d words still queued", model_q.size());
      error_count++;
    end
    repeat (20) @(posedge push_clk);
    #1;
    check_eq("sender_credits + credit_count", credits + int'(credit_count), cdc_fifo_pkg::depth);
    check_eq("push_slots", push_slots, cdc_fifo_pkg::depth);
    check_eq("pop_empty", pop_empty, 1);
    check_eq("pop_count", pop_count, push_count);
    finish_run();
  end

  // Watchdog sized from the number of planned pushes
  initial begin
    repeat (num_pushes * 40) @(posedge push_clk);
    $display("Watchdog expired after %0d push_clk cycles", num_pushes * 40);
    error_count++;
    finish_run();
  end

endmodule

// File: src/cdc_fifo_flops_push_credit.sv
// Dual-clock FIFO top: credit/valid push side, ready/valid pop side.
// Joins both controllers, the two pointer synchronizers and the flop RAM.

`timescale 1ns/10ps

module cdc_fifo_flops_push_credit (
  input  logic                 push_clk,
  input  logic                 pop_clk,
  input  logic                 rst_n,

  // Push side, push_clk domain
  input  logic                 push_sender_in_reset,
  output logic                 push_receiver_in_reset,
  input  logic                 push_credit_stall,
  output logic                 push_credit,
  input  logic                 push_valid,
  input  cdc_fifo_pkg::data_t  push_data,
  output logic                 push_full,
  output cdc_fifo_pkg::count_t push_slots,
  output cdc_fifo_pkg::count_t credit_count,

  // Pop side, pop_clk domain
  input  logic                 pop_ready,
  output logic                 pop_valid,
  output cdc_fifo_pkg::data_t  pop_data,
  output logic                 pop_empty,
  output cdc_fifo_pkg::count_t pop_items
);

  // RAM write port, push domain
  logic                wr_en;
  cdc_fifo_pkg::addr_t wr_addr;
  cdc_fifo_pkg::data_t wr_data;

  // RAM read port, addressed from the pop domain
  cdc_fifo_pkg::addr_t rd_addr;
  cdc_fifo_pkg::data_t rd_data;

  // Pointer crossings in both directions
  cdc_fifo_pkg::ptr_t  wr_ptr_gray;
  cdc_fifo_pkg::ptr_t  wr_ptr_synced;
  cdc_fifo_pkg::ptr_t  rd_ptr_gray;
  cdc_fifo_pkg::ptr_t  rd_ptr_synced;

  cdc_fifo_push_ctrl push_ctrl_i (
    .push_clk               (push_clk),
    .rst_n                  (rst_n),
    .push_sender_in_reset   (push_sender_in_reset),
    .push_credit_stall      (push_credit_stall),
    .push_valid             (push_valid),
    .push_data              (push_data),
    .rd_ptr_synced          (rd_ptr_synced),
    .push_receiver_in_reset (push_receiver_in_reset),
    .push_credit            (push_credit),
    .push_full              (push_full),
    .push_slots             (push_slots),
    .credit_count           (credit_count),
    .wr_en                  (wr_en),
    .wr_addr                (wr_addr),
    .wr_data                (wr_data),
    .wr_ptr_gray            (wr_ptr_gray)
  );

  flop_ram_1r1w ram_i (
    .push_clk (push_clk),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  // Write pointer into the pop domain
  gray_ptr_sync wr_sync_i (
    .dst_clk  (pop_clk),
    .rst_n    (rst_n),
    .ptr_gray (wr_ptr_gray),
    .ptr_bin  (wr_ptr_synced)
  );

  // Read pointer back into the push domain for slots and credit return
  gray_ptr_sync rd_sync_i (
    .dst_clk  (push_clk),
    .rst_n    (rst_n),
    .ptr_gray (rd_ptr_gray),
    .ptr_bin  (rd_ptr_synced)
  );

  cdc_fifo_pop_ctrl pop_ctrl_i (
    .pop_clk       (pop_clk),
    .rst_n         (rst_n),
    .pop_ready     (pop_ready),
    .wr_ptr_synced (wr_ptr_synced),
    .rd_data       (rd_data),
    .rd_addr       (rd_addr),
    .rd_ptr_gray   (rd_ptr_gray),
    .pop_valid     (pop_valid),
    .pop_data      (pop_data),
    .pop_empty     (pop_empty),
    .pop_items     (pop_items)
  );

endmodule

// File: src/cdc_fifo_pkg.sv
// Shared sizing and vector types for the dual-clock FIFO with push credit.
// Every RTL file and the testbench refer to these by scoped name.

package cdc_fifo_pkg;

  // Number of entries held in the flop RAM
  localparam int depth = 8;

  // Width of one stored word in bits
  localparam int width = 16;

  // Flops in each Gray pointer synchronizer chain
  localparam int num_sync_stages = 3;

  // RAM address width
  localparam int addr_width = $clog2(depth);

  // Pointers carry one extra wrap bit so full and empty can be told apart
  localparam int ptr_width = addr_width + 1;

  // Counts must hold every value from 0 up to and including depth
  localparam int count_width = $clog2(depth + 1);

  // One FIFO entry
  typedef logic [width-1:0] data_t;

  // RAM row index
  typedef logic [addr_width-1:0] addr_t;

  // Read or write pointer, binary or Gray coded
  typedef logic [ptr_width-1:0] ptr_t;

  // Occupancy, free slots or credit count
  typedef logic [count_width-1:0] count_t;

endpackage

// File: src/cdc_fifo_pop_ctrl.sv
// Pop-domain control of the dual-clock FIFO: read pointer, ready/valid
// output, occupancy status and zero-qualified read data.

`timescale 1ns/10ps

module cdc_fifo_pop_ctrl (
  input  logic                 pop_clk,
  input  logic                 rst_n,
  input  logic                 pop_ready,
  input  cdc_fifo_pkg::ptr_t   wr_ptr_synced,
  input  cdc_fifo_pkg::data_t  rd_data,
  output cdc_fifo_pkg::addr_t  rd_addr,
  output cdc_fifo_pkg::ptr_t   rd_ptr_gray,
  output logic                 pop_valid,
  output cdc_fifo_pkg::data_t  pop_data,
  output logic                 pop_empty,
  output cdc_fifo_pkg::count_t pop_items
);

  // Binary read pointer and the Gray copy that crosses to the push side
  cdc_fifo_pkg::ptr_t rd_ptr_q;
  cdc_fifo_pkg::ptr_t rd_ptr_next;
  cdc_fifo_pkg::ptr_t rd_ptr_gray_q;

  // Distance from read pointer to synchronized write pointer
  cdc_fifo_pkg::ptr_t stored;

  // Handshake completes this cycle
  logic pop_fire;

  assign stored    = wr_ptr_synced - rd_ptr_q;
  assign pop_items = cdc_fifo_pkg::count_t'(stored);

  // Any entry the write pointer has passed is safe to present
  assign pop_valid = (pop_items != '0);
  assign pop_empty = !pop_valid;
  assign pop_fire  = pop_valid && pop_ready;

  assign rd_ptr_next = rd_ptr_q + cdc_fifo_pkg::ptr_t'(1);

  // Pointer moves on the handshake; the next row is read at once
  always_ff @(posedge pop_clk) begin
    if (!rst_n) begin
      rd_ptr_q      <= '0;
      rd_ptr_gray_q <= '0;
    end else if (pop_fire) begin
      rd_ptr_q      <= rd_ptr_next;
      rd_ptr_gray_q <= rd_ptr_next ^ (rd_ptr_next >> 1);
    end
  end

  assign rd_addr     = rd_ptr_q[cdc_fifo_pkg::addr_width-1:0];
  assign rd_ptr_gray = rd_ptr_gray_q;

  // Stale or unwritten rows never leak out; data is zero without valid
  assign pop_data = rd_data & {cdc_fifo_pkg::width{pop_valid}};

endmodule

// File: src/cdc_fifo_push_ctrl.sv
// Push-domain control of the dual-clock FIFO: write pointer, status and
// the credit receiver that hands out one credit per free entry.

`timescale 1ns/10ps

module cdc_fifo_push_ctrl (
  input  logic                 push_clk,
  input  logic                 rst_n,
  input  logic                 push_sender_in_reset,
  input  logic                 push_credit_stall,
  input  logic                 push_valid,
  input  cdc_fifo_pkg::data_t  push_data,
  input  cdc_fifo_pkg::ptr_t   rd_ptr_synced,
  output logic                 push_receiver_in_reset,
  output logic                 push_credit,
  output logic                 push_full,
  output cdc_fifo_pkg::count_t push_slots,
  output cdc_fifo_pkg::count_t credit_count,
  output logic                 wr_en,
  output cdc_fifo_pkg::addr_t  wr_addr,
  output cdc_fifo_pkg::data_t  wr_data,
  output cdc_fifo_pkg::ptr_t   wr_ptr_gray
);

  // Binary write pointer and its Gray copy that crosses to the pop side
  cdc_fifo_pkg::ptr_t wr_ptr_q;
  cdc_fifo_pkg::ptr_t wr_ptr_next;
  cdc_fifo_pkg::ptr_t wr_ptr_gray_q;

  // Entries written but not yet seen as freed by the pop side
  cdc_fifo_pkg::ptr_t used;

  // Last synchronized read pointer that was already turned into credit
  cdc_fifo_pkg::ptr_t rd_ptr_seen_q;
  cdc_fifo_pkg::ptr_t freed;

  // Credits held here and not yet sent to the sender
  cdc_fifo_pkg::count_t credit_q;

  // Set one cycle after reset release; credits flow only once it is up
  logic active_q;

  always_ff @(posedge push_clk) begin
    if (!rst_n) begin
      active_q <= 1'b0;
    end else begin
      active_q <= 1'b1;
    end
  end

  // High through reset and the first cycle after it
  assign push_receiver_in_reset = !active_q;

  // The sender only pushes while it holds a credit, so every strobe is
  // accepted and goes straight to the RAM at this edge
  assign wr_en   = push_valid;
  assign wr_addr = wr_ptr_q[cdc_fifo_pkg::addr_width-1:0];
  assign wr_data = push_data;

  assign wr_ptr_next = wr_ptr_q + cdc_fifo_pkg::ptr_t'(1);

  // Gray copy is registered so the crossing sees a glitch-free source
  always_ff @(posedge push_clk) begin
    if (!rst_n) begin
      wr_ptr_q      <= '0;
      wr_ptr_gray_q <= '0;
    end else if (push_valid) begin
      wr_ptr_q      <= wr_ptr_next;
      wr_ptr_gray_q <= wr_ptr_next ^ (wr_ptr_next >> 1);
    end
  end

  assign wr_ptr_gray = wr_ptr_gray_q;

  // Occupancy as seen from this side; lags real pops by the sync delay
  // The wrap bit keeps the difference correct across pointer rollover
  assign used       = wr_ptr_q - rd_ptr_synced;
  assign push_slots = cdc_fifo_pkg::count_t'(cdc_fifo_pkg::depth)
                    - cdc_fifo_pkg::count_t'(used);
  assign push_full  = (push_slots == '0);

  // Entries freed since the last cycle, normally zero or one
  assign freed = rd_ptr_synced - rd_ptr_seen_q;

  always_ff @(posedge push_clk) begin
    if (!rst_n) begin
      rd_ptr_seen_q <= '0;
    end else begin
      rd_ptr_seen_q <= rd_ptr_synced;
    end
  end

  // One credit per cycle while any are held and the link allows it
  assign push_credit = active_q && (credit_q != '0) && !push_credit_stall
                    && !push_sender_in_reset;

  // Counter starts full so the sender gets depth initial credits
  // Freed entries add, each pulse sent subtracts one
  always_ff @(posedge push_clk) begin
    if (!rst_n) begin
      credit_q <= cdc_fifo_pkg::count_t'(cdc_fifo_pkg::depth);
    end else begin
      credit_q <= credit_q + cdc_fifo_pkg::count_t'(freed)
                - cdc_fifo_pkg::count_t'(push_credit);
    end
  end

  assign credit_count = credit_q;

endmodule

// File: src/flop_ram_1r1w.sv
// Flop-based storage with one write port and one read port.
// Written from the push domain, read combinationally from the pop domain.

`timescale 1ns/10ps

module flop_ram_1r1w (
  input  logic                push_clk,
  input  logic                wr_en,
  input  cdc_fifo_pkg::addr_t wr_addr,
  input  cdc_fifo_pkg::data_t wr_data,
  input  cdc_fifo_pkg::addr_t rd_addr,
  output cdc_fifo_pkg::data_t rd_data
);

  // Storage rows, one per FIFO entry
  cdc_fifo_pkg::data_t mem [cdc_fifo_pkg::depth];

  // A write lands at the same edge that carries the push strobe
  always_ff @(posedge push_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read is a plain mux on the stored rows
  // The pop side only addresses rows that the synchronized write pointer
  // has already covered, so the row it selects is stable by then
  assign rd_data = mem[rd_addr];

endmodule

// File: src/gray_ptr_sync.sv
// Brings a Gray-coded FIFO pointer into another clock domain.
// Used once per direction; the output is the pointer in binary form.

`timescale 1ns/10ps

module gray_ptr_sync (
  input  logic               dst_clk,
  input  logic               rst_n,
  input  cdc_fifo_pkg::ptr_t ptr_gray,
  output cdc_fifo_pkg::ptr_t ptr_bin
);

  // Synchronizer chain, index 0 samples the source register directly
  cdc_fifo_pkg::ptr_t sync_q [cdc_fifo_pkg::num_sync_stages];

  // Gray value at the end of the chain
  cdc_fifo_pkg::ptr_t gray_last;

  always_ff @(posedge dst_clk) begin
    if (!rst_n) begin
      for (int i = 0; i < cdc_fifo_pkg::num_sync_stages; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= ptr_gray;
      for (int i = 1; i < cdc_fifo_pkg::num_sync_stages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // Only one bit of the source changes per update, so the first stage
  // settles on either the old or the new pointer and never a mix of both
  assign gray_last = sync_q[cdc_fifo_pkg::num_sync_stages-1];

  // Gray to binary: each binary bit is the XOR of all Gray bits at or above it
  // Walk down from the MSB and carry the running XOR
  always_comb begin
    ptr_bin[cdc_fifo_pkg::ptr_width-1] = gray_last[cdc_fifo_pkg::ptr_width-1];
    for (int i = cdc_fifo_pkg::ptr_width - 2; i >= 0; i--) begin
      ptr_bin[i] = ptr_bin[i+1] ^ gray_last[i];
    end
  end

endmodule
